// File: design/heapPkg.sv
/*
  Array heap definitions
  Widths, opcodes, error codes and the structs passed between blocks
*/
package heapPkg;

  // --------------------------------------------------------------------------
  // Widths
  localparam int arrayBits   = 2;                          // Bits in an array number
  localparam int indexBits   = 3;                          // Bits in an element index
  localparam int arrayLength = 2 ** indexBits;             // Words per array
  localparam int dataBits    = 12;                         // Element width
  localparam int sizeBits    = indexBits + 1;              // Holds a full size
  localparam int arrayCount  = 2 ** arrayBits;             // Arrays the memory has room for

  // --------------------------------------------------------------------------
  // Opcodes and error codes
  typedef enum logic [3:0] {
    opClear,                                               // Every array unallocated
    opAlloc,                                               // Hand out an array
    opFree,                                                // Give an array back
    opWrite,                                               // Write, growing if needed
    opRead,
    opSize,
    opResize,
    opPush,
    opPop,
    opUp,                                                  // Insert, shift rest up
    opDown                                                 // Remove, shift rest down
  } heapOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory,
    errTooLarge
  } heapError;

  typedef enum logic [2:0] {
    allocNone,
    allocClearAll,
    allocAllocate,
    allocRelease,
    allocSetSize
  } allocAction;

  // --------------------------------------------------------------------------
  // Structs
  typedef struct packed {
    heapOp                op;                              // Opcode in the top bits
    logic [arrayBits-1:0] array;
    logic [indexBits-1:0] index;
  } heapAddress;

  typedef struct packed {
    logic                allocated;
    logic [sizeBits-1:0] size;
  } arrayStatus;

  typedef struct packed {
    allocAction           action;
    logic [arrayBits-1:0] array;
    logic [sizeBits-1:0]  size;                            // New size for setSize
  } sizeUpdate;

  typedef struct packed {
    logic                 enable;
    logic [arrayBits-1:0] array;
    logic [indexBits-1:0] index;
    logic [dataBits-1:0]  data;
  } storeWrite;

endpackage

// File: design/shiftCounter.sv
/*
  Shift counter
  Loadable up/down counter pacing the element moves of Up and Down
*/
module shiftCounter (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          load,
  input  logic                          down,
  input  logic [heapPkg::indexBits-1:0] start,
  input  logic [heapPkg::indexBits-1:0] limit,
  output logic [heapPkg::indexBits-1:0] pos,
  output logic                          last
);
  import heapPkg::*;

  logic [indexBits-1:0] limitReg;
  logic                 downReg;

  assign last = pos == limitReg;                           // Also holds once stopped

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pos      <= '0;
      limitReg <= '0;
      downReg  <= 1'b0;
    end else if (load) begin
      pos      <= start;
      limitReg <= limit;
      downReg  <= down;
    end else if (!last) begin
      pos <= downReg ? pos - 1'b1 : pos + 1'b1;
    end
  end

  // Start must lie on the near side of the limit
  assert property (@(posedge clock) disable iff (!resetN)
    downReg ? pos >= limitReg : pos <= limitReg);

endmodule

// File: design/arrayAllocator.sv
/*
  Array allocator
  Per array size and allocation flag, a LIFO of freed arrays and a
  count of arrays ever handed out
*/
module arrayAllocator #(
  parameter int maxArrays = 3
) (
  input  logic                          clock,
  input  logic                          resetN,
  input  heapPkg::sizeUpdate            update,
  input  logic [heapPkg::arrayBits-1:0] queryArray,
  output heapPkg::arrayStatus           status,
  output logic [heapPkg::arrayBits-1:0] newArray,
  output logic                          outOfArrays
);
  import heapPkg::*;

  localparam int countBits = $clog2(maxArrays + 1);

  logic [sizeBits-1:0]  sizes [arrayCount];
  logic [arrayCount-1:0] allocated;
  logic [arrayBits-1:0] freeStack [maxArrays];
  logic [countBits-1:0] freeTop;                           // Entries on the free stack
  logic [countBits-1:0] usedCount;                         // Arrays ever handed out

  assign status = '{allocated: allocated[queryArray], size: sizes[queryArray]};

  // Freed arrays come back first, newest first
  assign newArray    = freeTop != '0 ? freeStack[freeTop - 1'b1] : arrayBits'(usedCount);
  assign outOfArrays = freeTop == '0 && usedCount == countBits'(maxArrays);

  // --------------------------------------------------------------------------
  // Flags and counters
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      usedCount <= '0;
    end else begin
      case (update.action)
        allocClearAll: begin
          allocated <= '0;
          freeTop   <= '0;
          usedCount <= '0;
        end
        allocAllocate: begin
          allocated[update.array] <= 1'b1;
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;                     // Reuse top of stack
          end else begin
            usedCount <= usedCount + 1'b1;
          end
        end
        allocRelease: begin
          allocated[update.array] <= 1'b0;                 // The freed array itself
          freeTop                 <= freeTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Size table and free stack
  always_ff @(posedge clock) begin
    if (update.action == allocAllocate) begin
      sizes[update.array] <= '0;                           // New arrays start empty
    end else if (update.action == allocSetSize) begin
      sizes[update.array] <= update.size;
    end
    if (update.action == allocRelease) begin
      freeStack[freeTop] <= update.array;
    end
  end

  // A release never pushes onto a full free stack
  assert property (@(posedge clock) disable iff (!resetN)
    update.action == allocRelease |-> freeTop < countBits'(maxArrays));

endmodule

// File: design/elementStore.sv
/*
  Element store
  Array words with a combinational read port and a clocked write port
*/
module elementStore (
  input  logic                          clock,
  input  heapPkg::storeWrite            write,
  input  logic [heapPkg::arrayBits-1:0] readArray,
  input  logic [heapPkg::indexBits-1:0] readIndex,
  output logic [heapPkg::dataBits-1:0]  readData
);
  import heapPkg::*;

  // One fixed block of arrayLength words per array
  logic [dataBits-1:0] memory [arrayCount][arrayLength];

  assign readData = memory[readArray][readIndex];

  always_ff @(posedge clock) begin
    if (write.enable) begin
      memory[write.array][write.index] <= write.data;
    end
  end

endmodule

// File: design/heapSequencer.sv
/*
  Heap sequencer
  Decodes Wishbone requests, checks their preconditions, steers the
  allocator, element store and shift counter, and ends each bus cycle
*/
module heapSequencer (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          cyc,
  input  logic                          stb,
  input  heapPkg::heapAddress           adr,
  input  logic [heapPkg::dataBits-1:0]  datIn,
  output logic [heapPkg::dataBits-1:0]  datOut,
  output logic                          ack,
  output logic                          err,
  input  heapPkg::arrayStatus           status,
  input  logic [heapPkg::arrayBits-1:0] newArray,
  input  logic                          outOfArrays,
  output heapPkg::sizeUpdate            update,
  output heapPkg::storeWrite            write,
  output logic [heapPkg::arrayBits-1:0] readArray,
  output logic [heapPkg::indexBits-1:0] readIndex,
  input  logic [heapPkg::dataBits-1:0]  readData,
  output logic                          counterLoad,
  output logic                          counterDown,
  output logic [heapPkg::indexBits-1:0] counterStart,
  output logic [heapPkg::indexBits-1:0] counterLimit,
  input  logic [heapPkg::indexBits-1:0] counterPos,
  input  logic                          counterLast
);
  import heapPkg::*;

  typedef enum logic [1:0] {idle, shifting, respond} seqState;

  seqState             state;
  logic                failed;                             // Answer with err, not ack
  heapError            check;
  logic                request;
  logic                accept;
  logic                full;
  logic [sizeBits-1:0] wideIndex;
  logic [dataBits-1:0] nextData;

  assign request   = cyc && stb && state == idle;
  assign accept    = request && check == errNone;
  assign wideIndex = {1'b0, adr.index};
  assign full      = status.size == sizeBits'(arrayLength);
  assign readArray = adr.array;                            // Held steady for the whole cycle
  assign ack       = state == respond && !failed;
  assign err       = state == respond && failed;

  // --------------------------------------------------------------------------
  // Precondition checks
  always_comb begin
    check = errNone;
    if (adr.op == opAlloc) begin
      if (outOfArrays) check = errOutOfMemory;
    end else if (adr.op != opClear) begin
      if (!status.allocated) begin
        check = errNotAllocated;
      end else begin
        case (adr.op)
          opRead:   if (wideIndex >= status.size) check = errOutOfBounds;
          opUp:     if (wideIndex > status.size) check = errOutOfBounds;
          opPush:   if (full) check = errFull;
          opPop:    if (status.size == '0) check = errEmpty;
          opResize: if (datIn > dataBits'(arrayLength)) check = errTooLarge;
          opDown: begin
            if (status.size == '0) begin
              check = errEmpty;
            end else if (wideIndex >= status.size) begin
              check = errOutOfBounds;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Steering of allocator, store and counter
  always_comb begin
    update       = '{action: allocNone, array: adr.array, size: status.size};
    write        = '{enable: 1'b0, array: adr.array, index: adr.index, data: datIn};
    counterLoad  = 1'b0;
    counterDown  = 1'b0;
    counterStart = adr.index;
    counterLimit = adr.index;
    readIndex    = adr.index;
    nextData     = '0;

    if (state == shifting) begin
      // Up walks down from the top, Down walks up from the index
      readIndex   = adr.op == opUp ? counterPos - 1'b1 : counterPos + 1'b1;
      write.index = counterPos;
      if (adr.op == opUp) begin
        write.enable = 1'b1;
        write.data   = counterLast ? datIn : readData;     // New element goes in last
      end else begin
        write.enable = !counterLast;
        write.data   = readData;
      end
    end else if (adr.op == opPop) begin
      readIndex = indexBits'(status.size - 1'b1);          // Top element
    end

    if (accept) begin
      case (adr.op)
        opClear: update.action = allocClearAll;
        opAlloc: begin
          update.action = allocAllocate;
          update.array  = newArray;
          nextData      = dataBits'(newArray);
        end
        opFree: update.action = allocRelease;
        opWrite: begin
          write.enable = 1'b1;
          nextData     = datIn;
          if (wideIndex >= status.size) begin
            update.action = allocSetSize;
            update.size   = wideIndex + 1'b1;
          end
        end
        opRead: nextData = readData;
        opSize: nextData = dataBits'(status.size);
        opResize: begin
          update.action = allocSetSize;
          update.size   = sizeBits'(datIn);
        end
        opPush: begin
          write.enable  = 1'b1;
          write.index   = status.size[indexBits-1:0];
          update.action = allocSetSize;
          update.size   = status.size + 1'b1;
        end
        opPop: begin
          nextData      = readData;
          update.action = allocSetSize;
          update.size   = status.size - 1'b1;
        end
        opUp: begin
          counterLoad   = 1'b1;
          counterDown   = 1'b1;
          counterStart  = full ? indexBits'(arrayLength - 1) : status.size[indexBits-1:0];
          update.action = allocSetSize;
          update.size   = full ? status.size : status.size + 1'b1;  // Full drops its last word
        end
        opDown: begin
          counterLoad   = 1'b1;
          counterLimit  = indexBits'(status.size - 1'b1);
          nextData      = readData;                        // Removed element
          update.action = allocSetSize;
          update.size   = status.size - 1'b1;
        end
        default: ;
      endcase
    end else begin
      nextData = dataBits'(check);                         // Error code on the data bus
    end
  end

  // --------------------------------------------------------------------------
  // FSM
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= idle;
      failed <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (request) begin
            failed <= !accept;
            state  <= accept && (adr.op == opUp || adr.op == opDown) ? shifting : respond;
          end
        end
        shifting: if (counterLast) state <= respond;
        default:  state <= idle;                           // One cycle of ack or err
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (request) datOut <= nextData;
  end

  // Responses only inside the bus cycle
  assert property (@(posedge clock) disable iff (!resetN)
    (ack || err) |-> cyc && stb);

endmodule

// File: design/heapTop.sv
/*
  Array heap top level
  Wishbone classic slave serving a small heap of fixed length arrays
*/
module heapTop #(
  parameter int maxArrays = 3                              // Arrays the allocator may hand out
) (
  input  logic                         clock,
  input  logic                         resetN,
  input  logic                         cyc,
  input  logic                         stb,
  input  heapPkg::heapAddress          adr,
  input  logic [heapPkg::dataBits-1:0] datIn,
  output logic [heapPkg::dataBits-1:0] datOut,
  output logic                         ack,
  output logic                         err
);
  import heapPkg::*;

  sizeUpdate            update;
  arrayStatus           status;
  storeWrite            write;
  logic [arrayBits-1:0] newArray;
  logic                 outOfArrays;
  logic [arrayBits-1:0] readArray;
  logic [indexBits-1:0] readIndex;
  logic [dataBits-1:0]  readData;
  logic                 counterLoad;
  logic                 counterDown;
  logic [indexBits-1:0] counterStart;
  logic [indexBits-1:0] counterLimit;
  logic [indexBits-1:0] counterPos;
  logic                 counterLast;

  heapSequencer i_sequencer (
    .clock, .resetN, .cyc, .stb, .adr, .datIn, .datOut, .ack, .err,
    .status, .newArray, .outOfArrays, .update, .write,
    .readArray, .readIndex, .readData,
    .counterLoad, .counterDown, .counterStart, .counterLimit,
    .counterPos, .counterLast
  );

  shiftCounter i_counter (
    .clock, .resetN,
    .load  (counterLoad),
    .down  (counterDown),
    .start (counterStart),
    .limit (counterLimit),
    .pos   (counterPos),
    .last  (counterLast)
  );

  arrayAllocator #(
    .maxArrays (maxArrays)
  ) i_allocator (
    .clock, .resetN, .update,
    .queryArray (adr.array),                               // Status always follows the bus
    .status, .newArray, .outOfArrays
  );

  elementStore i_store (
    .clock, .write, .readArray, .readIndex, .readData
  );

endmodule

// File: tests/heapChecker.sv
/*
  Heap response checker
  Compares each ack or err on the bus with the expected response, in order
*/
module heapChecker (
  input  logic                         clock,
  input  logic                         ack,
  input  logic                         err,
  input  heapPkg::heapAddress          adr,
  input  logic [heapPkg::dataBits-1:0] datOut,
  output int                           mismatches,
  output int                           responses
);
  timeunit 1ns;
  timeprecision 100ps;
  import heapPkg::*;

  logic                expectAck [$];                      // 1 for ack, 0 for err
  logic [dataBits-1:0] expectData [$];

  task automatic loadExpected();
    int          fd;
    string       line;
    logic [31:0] op, array, index, data, resp, result;
    fd = $fopen("tests/heapPatterns.txt", "r");
    if (fd == 0) begin
      $display("Checker cannot open the pattern file tests/heapPatterns.txt");
      mismatches++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", op, array, index, data, resp, result) == 6) begin
          expectAck.push_back(resp[0]);
          expectData.push_back(result[dataBits-1:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compareResponse();
    int n;
    n = responses;
    if (n >= expectAck.size()) begin
      $display("Extra response at %0t ns after the last request", $time);
      mismatches++;
    end else begin
      if (ack !== expectAck[n]) begin
        $display("[ERROR] request %0d op %h ack = %h, expected %h", n, adr.op, ack, expectAck[n]);
        mismatches++;
      end
      if (err !== !expectAck[n]) begin
        $display("[ERROR] request %0d op %h err = %h, expected %h", n, adr.op, err, !expectAck[n]);
        mismatches++;
      end
      if (datOut !== expectData[n]) begin
        $display("[ERROR] request %0d op %h datOut = %h, expected %h",
                 n, adr.op, datOut, expectData[n]);
        mismatches++;
      end
    end
    responses++;
  endtask

  initial begin
    mismatches = 0;
    responses  = 0;
    loadExpected();
  end

  // DUT outputs are settled at the falling edge
  always @(negedge clock) begin
    if (ack || err) compareResponse();
  end

endmodule

// File: tests/heapTb.sv
/*
  Array heap testbench
  Clock, reset and a Wishbone master that runs the requests of the pattern file
*/
module heapTb;
  timeunit 1ns;
  timeprecision 100ps;
  import heapPkg::*;

  localparam int maxArrays   = 3;
  localparam int resetCycles = 10;
  localparam int driveDelay  = 1;                          // After the rising edge
  localparam int cycleBudget = arrayLength + 4;            // Longest Up or Down plus handshake

  logic                clock = 1'b0;
  logic                resetN;
  logic                cyc;
  logic                stb;
  heapAddress          adr;
  logic [dataBits-1:0] datIn;
  logic [dataBits-1:0] datOut;
  logic                ack;
  logic                err;
  int                  mismatches;
  int                  responses;
  int                  missing;
  bit                  loaded;

  heapAddress          requests [$];
  logic [dataBits-1:0] requestData [$];

  always #4 clock = ~clock;                                // 8 ns period

  heapTop #(.maxArrays (maxArrays)) i_dut (
    .clock, .resetN, .cyc, .stb, .adr, .datIn, .datOut, .ack, .err
  );

  heapChecker i_checker (
    .clock, .ack, .err, .adr, .datOut, .mismatches, .responses
  );

  // --------------------------------------------------------------------------
  // Requests from the pattern file
  task automatic loadPatterns(output bit ok);
    int          fd;
    string       line;
    logic [31:0] op, array, index, data, resp, result;
    heapAddress  request;
    fd = $fopen("tests/heapPatterns.txt", "r");
    ok = fd != 0;
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", op, array, index, data, resp, result) == 6) begin
          request.op    = heapOp'(op[3:0]);
          request.array = array[arrayBits-1:0];
          request.index = index[indexBits-1:0];
          requests.push_back(request);
          requestData.push_back(data[dataBits-1:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  // One Wishbone classic cycle, held until ack or err
  task automatic runRequest(input int n);
    int waited;
    @(posedge clock);
    #driveDelay;
    adr    = requests[n];
    datIn  = requestData[n];
    cyc    = 1'b1;
    stb    = 1'b1;
    waited = 0;
    do begin
      @(posedge clock);
      #driveDelay;
      waited++;
    end while (!(ack || err) && waited < cycleBudget);
    if (!(ack || err)) $display("No response to request %0d within %0d cycles", n, waited);
    @(posedge clock);                                      // Response cycle ends here
    #driveDelay;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  initial begin
    bit ok;
    resetN  = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    adr     = '0;
    datIn   = '0;
    missing = 0;
    loaded  = 1'b0;
    loadPatterns(ok);
    if (!ok) begin
      $display("Cannot open the pattern file tests/heapPatterns.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (resetCycles) @(posedge clock);
      #driveDelay resetN = 1'b1;
      foreach (requests[n]) runRequest(n);
      repeat (2) @(posedge clock);
      if (requests.size() > responses) missing = requests.size() - responses;
      $display("%0d requests, %0d responses, %0d mismatches, %0d missing",
               requests.size(), responses, mismatches, missing);
      if (mismatches == 0 && missing == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  // Watchdog sized from the number of requests
  initial begin
    wait (loaded);
    repeat (requests.size() * cycleBudget + resetCycles) @(posedge clock);
    $display("Watchdog expired, the %0d requests did not finish in time", requests.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: project.f
design/heapPkg.sv
design/shiftCounter.sv
design/arrayAllocator.sv
design/elementStore.sv
design/heapSequencer.sv
design/heapTop.sv
tests/heapChecker.sv
tests/heapTb.sv

// File: Makefile
# Verilator simulation of the array heap

VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= simulate.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/heapPatterns.txt
# op array index data resp result, all hex; resp 1 means ack, 0 means err
# op 0 clear 1 alloc 2 free 3 write 4 read 5 size 6 resize 7 push 8 pop 9 up a down
0 0 0 000 1 000
1 0 0 000 1 000
1 0 0 000 1 001
1 0 0 000 1 002
1 0 0 000 0 005
3 0 0 000 1 000
3 0 1 001 1 001
3 0 2 002 1 002
5 0 0 000 1 003
4 0 1 000 1 001
4 0 3 000 0 002
6 0 0 009 0 006
7 2 0 0a0 1 000
7 2 0 0a1 1 000
7 2 0 0a2 1 000
7 2 0 0a3 1 000
7 2 0 0a4 1 000
7 2 0 0a5 1 000
7 2 0 0a6 1 000
7 2 0 0a7 1 000
7 2 0 0a8 0 003
8 2 0 000 1 0a7
8 2 0 000 1 0a6
8 2 0 000 1 0a5
8 2 0 000 1 0a4
8 2 0 000 1 0a3
8 2 0 000 1 0a2
8 2 0 000 1 0a1
8 2 0 000 1 0a0
8 2 0 000 0 004
9 0 2 099 1 000
4 0 0 000 1 000
4 0 1 000 1 001
4 0 2 000 1 099
4 0 3 000 1 002
5 0 0 000 1 004
a 0 1 000 1 001
4 0 1 000 1 099
4 0 2 000 1 002
5 0 0 000 1 003
2 1 0 000 1 000
2 1 0 000 0 001
4 1 0 000 0 001
1 0 0 000 1 001
5 1 0 000 1 000
